/* common/fib_defs.svh */
`ifndef FIB_DEFS_SVH
`define FIB_DEFS_SVH

////////////////////
// datapath sizing
////////////////////

// one data word, also the adder width
`define FIB_WORD_W 16

// register file depth, term k lives at k mod this
`define FIB_REG_N 16

////////////////////
// sequencing
////////////////////

// clocks per step enable pulse
`define FIB_TICK_DIV 4

// term count and term number width
// covers every count up to 63
`define FIB_COUNT_W 6

`endif

/* common/fibPkg.sv */
`default_nettype none

`include "fib_defs.svh"

package fibPkg;

    ////////////////////
    // plain vector types
    ////////////////////

    // one data word
    typedef logic [`FIB_WORD_W-1:0] fibWord_t;

    // register index, 16 entries
    typedef logic [$clog2(`FIB_REG_N)-1:0] regIdx_t;

    // term count or running term number
    typedef logic [`FIB_COUNT_W-1:0] termCount_t;

    ////////////////////
    // enums
    ////////////////////

    // alu operation select
    typedef enum logic {
        ALU_ADD    = 1'b0,  // a plus b
        ALU_PASS_A = 1'b1   // a unchanged
    } aluOp_t;

    // sequencer FSM states
    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_INIT0 = 3'd1,
        S_INIT1 = 3'd2,
        S_STEP  = 3'd3,
        S_READ  = 3'd4,
        S_DONE  = 3'd5
    } seqState_t;

    ////////////////////
    // structs
    ////////////////////

    // sequencer to datapath
    typedef struct packed {
        regIdx_t  rdA;
        regIdx_t  rdB;
        regIdx_t  wrAddr;
        logic     wrEn;
        logic     wrSelInit;  // init word instead of alu result
        fibWord_t initValue;
        aluOp_t   aluOp;
    } seqCtrl_t;

    // alu to sequencer
    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } aluFlags_t;

endpackage

`default_nettype wire

/* src/stepTick.sv */
`timescale 1ns/100ps
`default_nettype none

module stepTick #(
    parameter int DIV = 4
) (
    input  logic clk,
    input  logic rstN,
    output logic stepEn
);

    // counter width, at least one bit
    localparam int cntW = (DIV > 1) ? $clog2(DIV) : 1;

    logic [cntW-1:0] cnt;
    logic            wrap;

    // last count of the period
    assign wrap = (cnt == cntW'(DIV - 1));

    // free running, pulse registered on the wrap edge
    // first pulse lands DIV clocks after reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt    <= '0;
            stepEn <= 1'b0;
        end else begin
            stepEn <= wrap;
            cnt    <= wrap ? '0 : cnt + 1'b1;
        end
    end

    // pulse spacing must be a full period
    aStepSpacing: assert property (@(posedge clk) disable iff (!rstN)
        (DIV > 1 && stepEn) |=> !stepEn)
        else $error("stepEn high on two clocks in a row");

endmodule

`default_nettype wire

/* fibCore/fibSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module fibSequencer (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stepEn,
    input  logic               start,
    input  fibPkg::termCount_t termCount,
    input  logic               readReq,
    input  fibPkg::regIdx_t    readIdx,
    input  fibPkg::aluFlags_t  aluFlags,
    output fibPkg::seqCtrl_t   ctrl,
    output logic               resultValid,
    output logic               busy,
    output logic               done,
    output logic               overflow
);

    fibPkg::seqState_t  state;
    fibPkg::seqState_t  retState;   // where a readback goes back to
    fibPkg::termCount_t termNum;    // next term to write
    fibPkg::termCount_t target;     // requested terms, clamped
    fibPkg::regIdx_t    wrIdx;      // termNum mod 16
    fibPkg::regIdx_t    readIdxQ;
    logic               idleLike;
    logic               runEnd;
    logic               stepOvf;
    logic               stepWrite;

    ////////////////////
    // decode
    ////////////////////

    // strobes are taken here on any clock
    assign idleLike = (state == fibPkg::S_IDLE) || (state == fibPkg::S_DONE);

    // all requested terms already written
    assign runEnd = (state == fibPkg::S_STEP) && (termNum == target);

    // add carried and the term is dropped
    assign stepOvf = (state == fibPkg::S_STEP) && !runEnd && aluFlags.carry;

    // clean add, term gets stored
    assign stepWrite = (state == fibPkg::S_STEP) && !runEnd && !aluFlags.carry;

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = fibPkg::ALU_PASS_A;
        case (state)
            fibPkg::S_INIT0: begin
                // term 0 is zero
                ctrl.wrAddr    = wrIdx;
                ctrl.wrSelInit = 1'b1;
                ctrl.initValue = fibPkg::fibWord_t'(0);
                ctrl.wrEn      = stepEn;
            end
            fibPkg::S_INIT1: begin
                // term 1 is one
                ctrl.wrAddr    = wrIdx;
                ctrl.wrSelInit = 1'b1;
                ctrl.initValue = fibPkg::fibWord_t'(1);
                ctrl.wrEn      = stepEn;
            end
            fibPkg::S_STEP: begin
                // terms k-2 and k-1
                // index arithmetic wraps mod 16
                ctrl.rdA   = fibPkg::regIdx_t'(wrIdx - fibPkg::regIdx_t'(2));
                ctrl.rdB   = fibPkg::regIdx_t'(wrIdx - fibPkg::regIdx_t'(1));
                ctrl.wrAddr = wrIdx;
                ctrl.aluOp = fibPkg::ALU_ADD;
                // carry seen before the edge blocks the write
                ctrl.wrEn  = stepEn && stepWrite;
            end
            fibPkg::S_READ: begin
                // pass a through the alu, nothing written
                ctrl.rdA = readIdxQ;
            end
            default: begin
            end
        endcase
    end

    // one strobe per emitted term or readback
    assign resultValid = stepEn && ((state == fibPkg::S_INIT0) ||
                                    (state == fibPkg::S_INIT1) ||
                                    stepWrite ||
                                    (state == fibPkg::S_READ));

    // on the step that enters S_DONE
    assign done = stepEn && (runEnd || stepOvf);

    ////////////////////
    // state and status
    ////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= fibPkg::S_IDLE;
            retState <= fibPkg::S_IDLE;
            termNum  <= '0;
            target   <= '0;
            wrIdx    <= '0;
            busy     <= 1'b0;
            overflow <= 1'b0;
        end else begin
            case (state)
                fibPkg::S_IDLE, fibPkg::S_DONE: begin
                    // start beats readReq
                    if (start) begin
                        state    <= fibPkg::S_INIT0;
                        termNum  <= '0;
                        wrIdx    <= '0;
                        target   <= (termCount < fibPkg::termCount_t'(2)) ?
                                    fibPkg::termCount_t'(2) : termCount;
                        busy     <= 1'b1;
                        overflow <= 1'b0;
                    end else if (readReq) begin
                        state    <= fibPkg::S_READ;
                        retState <= state;
                    end
                end
                fibPkg::S_INIT0: begin
                    if (stepEn) begin
                        state <= fibPkg::S_INIT1;
                    end
                end
                fibPkg::S_INIT1: begin
                    if (stepEn) begin
                        state <= fibPkg::S_STEP;
                    end
                end
                fibPkg::S_STEP: begin
                    if (stepEn && (runEnd || stepOvf)) begin
                        state <= fibPkg::S_DONE;
                        busy  <= 1'b0;
                    end
                    // sticky until next start
                    if (stepEn && stepOvf) begin
                        overflow <= 1'b1;
                    end
                end
                fibPkg::S_READ: begin
                    if (stepEn) begin
                        state <= retState;
                    end
                end
                default: begin
                    state <= fibPkg::S_IDLE;
                end
            endcase
            // count every stored term
            if (ctrl.wrEn) begin
                termNum <= termNum + 1'b1;
                wrIdx   <= wrIdx + 1'b1;
            end
        end
    end

    // readback index captured with the strobe
    always_ff @(posedge clk) begin
        if (idleLike && !start && readReq) begin
            readIdxQ <= readIdx;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // register writes only come from the run states while busy
    aWrOnlyInRun: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.wrEn |-> (busy &&
                       (state inside {fibPkg::S_INIT0, fibPkg::S_INIT1, fibPkg::S_STEP})))
        else $error("register write outside a run state");

    // done step never carries a term and still sees busy
    aDoneNoValid: assert property (@(posedge clk) disable iff (!rstN)
        done |-> (busy && !resultValid))
        else $error("done and resultValid high together");

endmodule

`default_nettype wire

/* fibCore/regFile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fib_defs.svh"

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  fibPkg::regIdx_t  rdA,
    input  fibPkg::regIdx_t  rdB,
    input  fibPkg::regIdx_t  wrAddr,
    input  logic             wrEn,
    input  fibPkg::fibWord_t wrData,
    output fibPkg::fibWord_t rdDataA,
    output fibPkg::fibWord_t rdDataB
);

    ////////////////////
    // storage
    ////////////////////

    fibPkg::fibWord_t regs [`FIB_REG_N];

    // every entry reads zero after reset
    // single write port, lands on the clock edge
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `FIB_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    // combinational, same cycle as the index
    // port a feeds alu a, also used for readback
    assign rdDataA = regs[rdA];

    // port b feeds alu b
    assign rdDataB = regs[rdB];

endmodule

`default_nettype wire

/* fibCore/alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fib_defs.svh"

module alu (
    input  logic              clk,
    input  logic              rstN,
    input  fibPkg::fibWord_t  opA,
    input  fibPkg::fibWord_t  opB,
    input  fibPkg::aluOp_t    aluOp,
    input  logic              latch,
    output fibPkg::fibWord_t  result,
    output fibPkg::aluFlags_t flags,
    output fibPkg::aluFlags_t flagsReg
);

    // one extra bit catches the carry
    logic [`FIB_WORD_W:0] sum;
    logic                 carryOut;

    assign sum = {1'b0, opA} + {1'b0, opB};

    ////////////////////
    // operation
    ////////////////////

    always_comb begin
        result   = opA;
        carryOut = 1'b0;
        case (aluOp)
            fibPkg::ALU_ADD: begin
                result   = sum[`FIB_WORD_W-1:0];
                carryOut = sum[`FIB_WORD_W];
            end
            fibPkg::ALU_PASS_A: begin
                // readback and init words
                result   = opA;
                carryOut = 1'b0;
            end
            default: begin
                result   = opA;
                carryOut = 1'b0;
            end
        endcase
    end

    ////////////////////
    // flags
    ////////////////////

    // live flags of the current result
    always_comb begin
        flags.carry    = carryOut;
        flags.zero     = (result == '0);
        flags.negative = result[`FIB_WORD_W-1];
    end

    // status register
    // updated only when the result is stored
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flagsReg <= '0;
        end else if (latch) begin
            flagsReg <= flags;
        end
    end

endmodule

`default_nettype wire

/* src/fibTop.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fib_defs.svh"

module fibTop (
    input  logic               clk,
    input  logic               rstN,
    input  logic               start,
    input  fibPkg::termCount_t termCount,
    input  logic               readReq,
    input  fibPkg::regIdx_t    readIdx,
    output fibPkg::fibWord_t   result,
    output logic               resultValid,
    output logic               busy,
    output logic               done,
    output logic               overflow,
    output logic               lastZero
);

    logic              stepEn;
    fibPkg::seqCtrl_t  ctrl;
    fibPkg::aluFlags_t aluFlags;
    fibPkg::aluFlags_t flagsReg;
    fibPkg::fibWord_t  rdDataA;
    fibPkg::fibWord_t  rdDataB;
    fibPkg::fibWord_t  aluOpA;
    fibPkg::fibWord_t  writeData;

    // step rate
    stepTick #(
        .DIV (`FIB_TICK_DIV)
    ) stepTick_inst (
        .clk    (clk),
        .rstN   (rstN),
        .stepEn (stepEn)
    );

    ////////////////////
    // control
    ////////////////////

    fibSequencer fibSequencer_inst (
        .clk         (clk),
        .rstN        (rstN),
        .stepEn      (stepEn),
        .start       (start),
        .termCount   (termCount),
        .readReq     (readReq),
        .readIdx     (readIdx),
        .aluFlags    (aluFlags),
        .ctrl        (ctrl),
        .resultValid (resultValid),
        .busy        (busy),
        .done        (done),
        .overflow    (overflow)
    );

    ////////////////////
    // datapath
    ////////////////////

    regFile regFile_inst (
        .clk     (clk),
        .rstN    (rstN),
        .rdA     (ctrl.rdA),
        .rdB     (ctrl.rdB),
        .wrAddr  (ctrl.wrAddr),
        .wrEn    (ctrl.wrEn),
        .wrData  (writeData),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    // write source select, ahead of alu a
    // init words pass through unchanged so the flags follow them too
    assign aluOpA = ctrl.wrSelInit ? ctrl.initValue : rdDataA;

    alu alu_inst (
        .clk      (clk),
        .rstN     (rstN),
        .opA      (aluOpA),
        .opB      (rdDataB),
        .aluOp    (ctrl.aluOp),
        .latch    (ctrl.wrEn),
        .result   (writeData),
        .flags    (aluFlags),
        .flagsReg (flagsReg)
    );

    // every stored term and every readback shows here
    assign result   = writeData;
    assign lastZero = flagsReg.zero;

endmodule

`default_nettype wire

/* sim/fibTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fib_defs.svh"

module fibTb;

    // 5 runs, 16 readbacks, overflow run, restart run
    localparam int NUM_FIXED = 23;
    localparam int NUM_RAND  = 6;
    localparam int NUM_TESTS = NUM_FIXED + NUM_RAND;
    // largest value one word holds
    localparam longint unsigned WORD_MAX = (64'd1 << `FIB_WORD_W) - 1;

    logic               clk;
    logic               rstN;
    logic               start;
    fibPkg::termCount_t termCount;
    logic               readReq;
    fibPkg::regIdx_t    readIdx;
    fibPkg::fibWord_t   result;
    logic               resultValid;
    logic               busy;
    logic               done;
    logic               overflow;
    logic               lastZero;

    ////////////////////
    // stimulus table
    ////////////////////

    string           testName [NUM_TESTS];
    bit              isRead   [NUM_TESTS];
    int              arg      [NUM_TESTS];  // termCount or readIdx
    int              expTerms [NUM_TESTS];
    bit              expOvf   [NUM_TESTS];
    int              tableLen;
    // what the register file should hold
    longint unsigned modelRegs [`FIB_REG_N];
    int              errorCount;
    int              checkCount;
    int              cycleCount;
    int              cycleLimit;
    logic [31:0]     lfsrState;

    fibTop fibTop_inst (
        .clk         (clk),
        .rstN        (rstN),
        .start       (start),
        .termCount   (termCount),
        .readReq     (readReq),
        .readIdx     (readIdx),
        .result      (result),
        .resultValid (resultValid),
        .busy        (busy),
        .done        (done),
        .overflow    (overflow),
        .lastZero    (lastZero)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reference sequence
    // 64 bits hold term 63
    function automatic longint unsigned fibRef(input int k);
        longint unsigned a;
        longint unsigned b;
        longint unsigned t;
        a = 0;
        b = 1;
        for (int i = 0; i < k; i++) begin
            t = a + b;
            a = b;
            b = t;
        end
        return a;
    endfunction

    // clamp to 2 and stop at the first term too wide for a word
    function automatic int termsFor(input int count);
        int n;
        n = (count < 2) ? 2 : count;
        for (int k = 2; k < n; k++) begin
            if (fibRef(k) > WORD_MAX) begin
                return k;
            end
        end
        return n;
    endfunction

    // galois lfsr shifting right
    // one bit out per step
    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h80200003;
        end
        return outBit;
    endfunction

    task automatic setEntry(input string name, input bit rd, input int a,
                            input int terms, input bit ovf);
        testName[tableLen] = name;
        isRead[tableLen]   = rd;
        arg[tableLen]      = a;
        expTerms[tableLen] = terms;
        expOvf[tableLen]   = ovf;
        tableLen++;
    endtask

    task automatic buildTable();
        int count;
        int terms;
        setEntry("run10", 1'b0, 10, 10, 1'b0);
        setEntry("clamp0", 1'b0, 0, 2, 1'b0);
        setEntry("clamp1", 1'b0, 1, 2, 1'b0);
        setEntry("run2", 1'b0, 2, 2, 1'b0);
        // index wraps past 16
        setEntry("wrap24", 1'b0, 24, 24, 1'b0);
        for (int r = 0; r < `FIB_REG_N; r++) begin
            setEntry($sformatf("read%0d", r), 1'b1, r, 1, 1'b0);
        end
        // term 25 carries out
        setEntry("ovf40", 1'b0, 40, 25, 1'b1);
        setEntry("restart5", 1'b0, 5, 5, 1'b0);
        for (int r = 0; r < NUM_RAND; r++) begin
            count = 0;
            for (int b = 0; b < `FIB_COUNT_W; b++) begin
                count = (count << 1) | int'(lfsrBit());
            end
            if (count < 2) begin
                count = count + 2;
            end
            terms = termsFor(count);
            setEntry($sformatf("rand%0d_n%0d", r, count), 1'b0, count, terms, terms < count);
        end
        // each entry gets twice its step budget
        cycleLimit = 100;
        for (int i = 0; i < tableLen; i++) begin
            cycleLimit += (expTerms[i] + 3) * `FIB_TICK_DIV * 2;
        end
    endtask

    task automatic reportMismatch(input string name, input longint unsigned expVal,
                                  input longint unsigned actVal);
        errorCount++;
        $display("CHECK FAILED %s: expected %0d, actual %0d", name, expVal, actVal);
    endtask

    ////////////////////
    // test steps
    ////////////////////

    task automatic applyRun(input int i);
        int              emitted;
        int              budget;
        bit              seenDone;
        bit              zeroPending;
        longint unsigned expVal;
        emitted = 0;
        seenDone = 0;
        zeroPending = 0;
        budget = (expTerms[i] + 3) * `FIB_TICK_DIV * 2;
        @(posedge clk);
        #1;
        start = 1'b1;
        termCount = fibPkg::termCount_t'(arg[i]);
        @(posedge clk);
        #1;
        start = 1'b0;
        // sample mid cycle away from both edges
        for (int w = 0; w < budget && !seenDone; w++) begin
            @(negedge clk);
            checkCount++;
            if (w == 0 && (busy !== 1'b1 || overflow !== 1'b0))
                reportMismatch({testName[i], " busy,overflow at start"}, 2, {busy, overflow});
            // term 0 was stored at the last edge
            if (zeroPending) begin
                zeroPending = 0;
                checkCount++;
                if (lastZero !== 1'b1)
                    reportMismatch({testName[i], " lastZero after term 0"}, 1, lastZero);
            end
            if (resultValid) begin
                expVal = fibRef(emitted);
                checkCount++;
                if (result !== fibPkg::fibWord_t'(expVal))
                    reportMismatch($sformatf("%s term %0d", testName[i], emitted),
                                   expVal, result);
                if (emitted == 0) begin
                    zeroPending = 1;
                end
                emitted++;
            end
            if (done) begin
                seenDone = 1;
            end
        end
        if (!seenDone) begin
            errorCount++;
            $display("%s: no done pulse within %0d cycles", testName[i], budget);
        end else begin
            // status settles one clock after done
            @(negedge clk);
            checkCount += 4;
            if (emitted != expTerms[i])
                reportMismatch({testName[i], " result count"}, expTerms[i], emitted);
            if (busy !== 1'b0)
                reportMismatch({testName[i], " busy after done"}, 0, busy);
            if (overflow !== expOvf[i])
                reportMismatch({testName[i], " overflow"}, expOvf[i], overflow);
            // last stored term is never zero
            if (lastZero !== 1'b0)
                reportMismatch({testName[i], " lastZero after run"}, 0, lastZero);
        end
        // term k lands in register k mod 16
        for (int k = 0; k < expTerms[i]; k++) begin
            modelRegs[k % `FIB_REG_N] = fibRef(k);
        end
    endtask

    task automatic applyRead(input int i);
        int              budget;
        bit              seenValid;
        longint unsigned expVal;
        seenValid = 0;
        budget = 4 * `FIB_TICK_DIV * 2;
        expVal = modelRegs[arg[i]];
        @(posedge clk);
        #1;
        readReq = 1'b1;
        readIdx = fibPkg::regIdx_t'(arg[i]);
        @(posedge clk);
        #1;
        readReq = 1'b0;
        for (int w = 0; w < budget && !seenValid; w++) begin
            @(negedge clk);
            if (done) begin
                errorCount++;
                $display("%s: done pulse during a readback", testName[i]);
            end
            if (resultValid) begin
                seenValid = 1;
                checkCount++;
                if (result !== fibPkg::fibWord_t'(expVal))
                    reportMismatch({testName[i], " value"}, expVal, result);
            end
        end
        if (!seenValid) begin
            errorCount++;
            $display("%s: no readback strobe within %0d cycles", testName[i], budget);
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        rstN = 1'b0;
        start = 1'b0;
        termCount = '0;
        readReq = 1'b0;
        readIdx = '0;
        errorCount = 0;
        checkCount = 0;
        tableLen = 0;
        lfsrState = 32'hbb1d6200;
        for (int k = 0; k < `FIB_REG_N; k++) begin
            modelRegs[k] = 0;
        end
        buildTable();
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        checkCount++;
        if ({resultValid, busy, done, overflow, lastZero} !== 5'b0)
            reportMismatch("reset outputs", 0, {resultValid, busy, done, overflow, lastZero});
        for (int i = 0; i < tableLen; i++) begin
            if (isRead[i]) begin
                applyRead(i);
            end else begin
                applyRun(i);
            end
        end
        $display("errors: %0d of %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // hang guard
    initial begin
        cycleCount = 0;
        while (cycleCount <= cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", cycleLimit);
        $display("errors: %0d of %0d checks", errorCount, checkCount);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/fibPkg.sv
src/stepTick.sv
fibCore/fibSequencer.sv
fibCore/regFile.sv
fibCore/alu.sv
src/fibTop.sv
sim/fibTb.sv

/* Bender.yml */
package:
  name: fib_engine

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fibPkg.sv
      - src/stepTick.sv
      - fibCore/fibSequencer.sv
      - fibCore/regFile.sv
      - fibCore/alu.sv
      - src/fibTop.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - sim/fibTb.sv
